// ==== filelist.f ====
rtl/ex_pkg.sv
rtl/ex_alu.sv
rtl/ex_mul.sv
rtl/hilo_reg.sv
rtl/ex_writeback.sv
rtl/ex_stage.sv
verif/ex_stage_asserts.sv
verif/tb_ex_stage.sv

// ==== rtl/ex_alu.sv ====
`timescale 1ns/1ps
`default_nettype none

module ex_alu (
    input  wire ex_pkg::aluop_t aluop_i,
    input  wire ex_pkg::word_t  reg1_i,
    input  wire ex_pkg::word_t  reg2_i,
    output ex_pkg::word_t       logic_res_o,
    output ex_pkg::word_t       shift_res_o,
    output ex_pkg::word_t       arith_res_o,
    output logic                ovf_o
);
    import ex_pkg::*;

    logic [SHAMT_W-1:0] shamt;
    logic               use_neg;
    word_t              reg2_mux;
    logic               b_sign;
    word_t              sum;
    logic               sum_ovf;
    logic               lt_signed;
    logic               lt;

    // number of zero bits above the first one
    function automatic word_t lead_zeros(input word_t v);
        word_t n;
        logic  found;
        n = '0;
        found = 1'b0;
        for (int i = WORD_W - 1; i >= 0; i--) begin
            if (v[i]) begin
                found = 1'b1;
            end else if (!found) begin
                n = n + 1'b1;
            end
        end
        return n;
    endfunction

    always_comb begin
        case (aluop_i)
            OP_OR:   logic_res_o = reg1_i | reg2_i;
            OP_AND:  logic_res_o = reg1_i & reg2_i;
            OP_XOR:  logic_res_o = reg1_i ^ reg2_i;
            OP_NOR:  logic_res_o = ~(reg1_i | reg2_i);
            default: logic_res_o = '0;
        endcase
    end

    // shift amount comes from operand 1, data from operand 2
    assign shamt = reg1_i[SHAMT_W-1:0];

    always_comb begin
        case (aluop_i)
            OP_SLL:  shift_res_o = reg2_i << shamt;
            OP_SRL:  shift_res_o = reg2_i >> shamt;
            OP_SRA:  shift_res_o = word_t'($signed(reg2_i) >>> shamt);
            default: shift_res_o = '0;
        endcase
    end

    assign use_neg  = (aluop_i == OP_SUB) || (aluop_i == OP_SUBU) || (aluop_i == OP_SLT);
    assign reg2_mux = use_neg ? (~reg2_i + 1'b1) : reg2_i;
    assign sum      = reg1_i + reg2_mux;

    // sign of +b or -b, right even for the most negative b
    assign b_sign = reg2_i[WORD_W-1] ^ use_neg;

    assign sum_ovf = (reg1_i[WORD_W-1] && b_sign && !sum[WORD_W-1]) ||
                     (!reg1_i[WORD_W-1] && !b_sign && sum[WORD_W-1]);

    // only the trapping forms drop the write
    assign ovf_o = ((aluop_i == OP_ADD) || (aluop_i == OP_SUB)) && sum_ovf;

    // negative vs positive, otherwise sign of the difference
    assign lt_signed = (reg1_i[WORD_W-1] && !reg2_i[WORD_W-1]) ||
                       (!reg1_i[WORD_W-1] && !reg2_i[WORD_W-1] && sum[WORD_W-1]) ||
                       (reg1_i[WORD_W-1] && reg2_i[WORD_W-1] && sum[WORD_W-1]);
    assign lt = (aluop_i == OP_SLT) ? lt_signed : (reg1_i < reg2_i);

    always_comb begin
        case (aluop_i)
            OP_SLT, OP_SLTU:                   arith_res_o = {{(WORD_W-1){1'b0}}, lt};
            OP_ADD, OP_ADDU, OP_SUB, OP_SUBU:  arith_res_o = sum;
            OP_CLZ:                            arith_res_o = lead_zeros(reg1_i);
            OP_CLO:                            arith_res_o = lead_zeros(~reg1_i);
            default:                           arith_res_o = '0;
        endcase
    end

endmodule

`default_nettype wire

// ==== rtl/ex_mul.sv ====
`timescale 1ns/1ps
`default_nettype none

module ex_mul (
    input  wire                 clk,
    input  wire                 rst_i,
    input  wire ex_pkg::aluop_t aluop_i,
    input  wire ex_pkg::word_t  reg1_i,
    input  wire ex_pkg::word_t  reg2_i,
    input  wire ex_pkg::word_t  hi_i,
    input  wire ex_pkg::word_t  lo_i,
    output ex_pkg::dword_t      mul_res_o,
    output ex_pkg::dword_t      mac_res_o,
    output logic                mac_done_o,
    output logic                stall_o
);
    import ex_pkg::*;

    logic       signed_op;
    logic       mac_op;
    logic       mac_sub;
    word_t      opa;
    word_t      opb;
    dword_t     prod_abs;
    mac_state_e state_q;
    dword_t     acc_term_q;

    assign signed_op = (aluop_i == OP_MUL) || (aluop_i == OP_MULT) ||
                       (aluop_i == OP_MADD) || (aluop_i == OP_MSUB);
    assign mac_sub   = (aluop_i == OP_MSUB) || (aluop_i == OP_MSUBU);
    assign mac_op    = mac_sub || (aluop_i == OP_MADD) || (aluop_i == OP_MADDU);

    // magnitudes for signed forms
    assign opa = (signed_op && reg1_i[WORD_W-1]) ? (~reg1_i + 1'b1) : reg1_i;
    assign opb = (signed_op && reg2_i[WORD_W-1]) ? (~reg2_i + 1'b1) : reg2_i;

    assign prod_abs = dword_t'(opa) * dword_t'(opb);

    // restore the sign when the operand signs differ
    assign mul_res_o = (signed_op && (reg1_i[WORD_W-1] ^ reg2_i[WORD_W-1])) ?
                       (~prod_abs + 1'b1) : prod_abs;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            state_q <= MAC_IDLE;
        end else begin
            case (state_q)
                MAC_IDLE: begin
                    if (mac_op) begin
                        state_q <= MAC_ACC;
                    end
                end
                default: state_q <= MAC_IDLE;
            endcase
        end
    end

    // partial term captured in the stall cycle
    always_ff @(posedge clk) begin
        if (state_q == MAC_IDLE && mac_op) begin
            acc_term_q <= mac_sub ? (~mul_res_o + 1'b1) : mul_res_o;
        end
    end

    assign stall_o    = mac_op && (state_q == MAC_IDLE);
    assign mac_done_o = (state_q == MAC_ACC);
    assign mac_res_o  = {hi_i, lo_i} + acc_term_q;

endmodule

`default_nettype wire

// ==== rtl/ex_pkg.sv ====
`default_nettype none

package ex_pkg;

    localparam int WORD_W     = 32;
    localparam int REG_ADDR_W = 5;
    localparam int SHAMT_W    = 5;

    typedef logic [WORD_W-1:0]     word_t;
    typedef logic [2*WORD_W-1:0]   dword_t;
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;
    typedef logic [7:0]            aluop_t;
    typedef logic [2:0]            alusel_t;

    // operation codes, same encoding as the decode stage
    localparam aluop_t OP_NOP   = 8'b0000_0000;
    localparam aluop_t OP_OR    = 8'b0010_0101;
    localparam aluop_t OP_AND   = 8'b0010_0100;
    localparam aluop_t OP_XOR   = 8'b0010_0110;
    localparam aluop_t OP_NOR   = 8'b0010_0111;
    localparam aluop_t OP_SLL   = 8'b0111_1100;
    localparam aluop_t OP_SRL   = 8'b0000_0010;
    localparam aluop_t OP_SRA   = 8'b0000_0011;
    localparam aluop_t OP_ADD   = 8'b0010_0000;
    localparam aluop_t OP_ADDU  = 8'b0010_0001;
    localparam aluop_t OP_SUB   = 8'b0010_0010;
    localparam aluop_t OP_SUBU  = 8'b0010_0011;
    localparam aluop_t OP_SLT   = 8'b0010_1010;
    localparam aluop_t OP_SLTU  = 8'b0010_1011;
    localparam aluop_t OP_CLZ   = 8'b1011_0000;
    localparam aluop_t OP_CLO   = 8'b1011_0001;
    localparam aluop_t OP_MUL   = 8'b1010_1001;
    localparam aluop_t OP_MULT  = 8'b0001_1000;
    localparam aluop_t OP_MULTU = 8'b0001_1001;
    localparam aluop_t OP_MADD  = 8'b1010_0110;
    localparam aluop_t OP_MADDU = 8'b1010_1000;
    localparam aluop_t OP_MSUB  = 8'b1010_1010;
    localparam aluop_t OP_MSUBU = 8'b1010_1011;
    localparam aluop_t OP_MFHI  = 8'b0001_0000;
    localparam aluop_t OP_MFLO  = 8'b0001_0010;
    localparam aluop_t OP_MTHI  = 8'b0001_0001;
    localparam aluop_t OP_MTLO  = 8'b0001_0011;

    // result classes
    localparam alusel_t SEL_NOP   = 3'b000;
    localparam alusel_t SEL_LOGIC = 3'b001;
    localparam alusel_t SEL_SHIFT = 3'b010;
    localparam alusel_t SEL_MOVE  = 3'b011;
    localparam alusel_t SEL_ARITH = 3'b100;
    localparam alusel_t SEL_MUL   = 3'b101;

    // two-cycle multiply-accumulate
    typedef enum logic {
        MAC_IDLE,
        MAC_ACC
    } mac_state_e;

endpackage

`default_nettype wire

// ==== rtl/ex_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module ex_stage (
    input  wire                    clk,
    input  wire                    rst_i,
    input  wire ex_pkg::aluop_t    aluop_i,
    input  wire ex_pkg::alusel_t   alusel_i,
    input  wire ex_pkg::word_t     reg1_i,
    input  wire ex_pkg::word_t     reg2_i,
    input  wire ex_pkg::reg_addr_t wd_i,
    input  wire                    wreg_i,
    output ex_pkg::reg_addr_t      wd_o,
    output logic                   wreg_o,
    output ex_pkg::word_t          wdata_o,
    output logic                   stall_o,
    output ex_pkg::word_t          hi_o,
    output ex_pkg::word_t          lo_o
);
    import ex_pkg::*;

    word_t  logic_res;
    word_t  shift_res;
    word_t  arith_res;
    logic   ovf;
    dword_t mul_res;
    dword_t mac_res;
    logic   mac_done;
    word_t  hi_q;
    word_t  lo_q;
    logic   hilo_we;
    word_t  hi_d;
    word_t  lo_d;

    ex_alu u_alu (
        .aluop_i     (aluop_i),
        .reg1_i      (reg1_i),
        .reg2_i      (reg2_i),
        .logic_res_o (logic_res),
        .shift_res_o (shift_res),
        .arith_res_o (arith_res),
        .ovf_o       (ovf)
    );

    ex_mul u_mul (
        .clk        (clk),
        .rst_i      (rst_i),
        .aluop_i    (aluop_i),
        .reg1_i     (reg1_i),
        .reg2_i     (reg2_i),
        .hi_i       (hi_q),
        .lo_i       (lo_q),
        .mul_res_o  (mul_res),
        .mac_res_o  (mac_res),
        .mac_done_o (mac_done),
        .stall_o    (stall_o)
    );

    hilo_reg u_hilo (
        .clk   (clk),
        .rst_i (rst_i),
        .we_i  (hilo_we),
        .hi_i  (hi_d),
        .lo_i  (lo_d),
        .hi_o  (hi_q),
        .lo_o  (lo_q)
    );

    ex_writeback u_wb (
        .aluop_i     (aluop_i),
        .alusel_i    (alusel_i),
        .wd_i        (wd_i),
        .wreg_i      (wreg_i),
        .logic_res_i (logic_res),
        .shift_res_i (shift_res),
        .arith_res_i (arith_res),
        .ovf_i       (ovf),
        .mul_res_i   (mul_res),
        .mac_res_i   (mac_res),
        .mac_done_i  (mac_done),
        .hi_i        (hi_q),
        .lo_i        (lo_q),
        .reg1_i      (reg1_i),
        .wd_o        (wd_o),
        .wreg_o      (wreg_o),
        .wdata_o     (wdata_o),
        .hilo_we_o   (hilo_we),
        .hi_o        (hi_d),
        .lo_o        (lo_d)
    );

    // current hi/lo for observation
    assign hi_o = hi_q;
    assign lo_o = lo_q;

endmodule

`default_nettype wire

// ==== rtl/ex_writeback.sv ====
`timescale 1ns/1ps
`default_nettype none

module ex_writeback (
    input  wire ex_pkg::aluop_t    aluop_i,
    input  wire ex_pkg::alusel_t   alusel_i,
    input  wire ex_pkg::reg_addr_t wd_i,
    input  wire                    wreg_i,
    input  wire ex_pkg::word_t     logic_res_i,
    input  wire ex_pkg::word_t     shift_res_i,
    input  wire ex_pkg::word_t     arith_res_i,
    input  wire                    ovf_i,
    input  wire ex_pkg::dword_t    mul_res_i,
    input  wire ex_pkg::dword_t    mac_res_i,
    input  wire                    mac_done_i,
    input  wire ex_pkg::word_t     hi_i,
    input  wire ex_pkg::word_t     lo_i,
    input  wire ex_pkg::word_t     reg1_i,
    output ex_pkg::reg_addr_t      wd_o,
    output logic                   wreg_o,
    output ex_pkg::word_t          wdata_o,
    output logic                   hilo_we_o,
    output ex_pkg::word_t          hi_o,
    output ex_pkg::word_t          lo_o
);
    import ex_pkg::*;

    word_t move_res;

    assign wd_o   = wd_i;
    assign wreg_o = wreg_i && !ovf_i;

    assign move_res = (aluop_i == OP_MFHI) ? hi_i :
                      (aluop_i == OP_MFLO) ? lo_i : '0;

    always_comb begin
        case (alusel_i)
            SEL_LOGIC: wdata_o = logic_res_i;
            SEL_SHIFT: wdata_o = shift_res_i;
            SEL_ARITH: wdata_o = arith_res_i;
            SEL_MUL:   wdata_o = mul_res_i[WORD_W-1:0];
            SEL_MOVE:  wdata_o = move_res;
            default:   wdata_o = '0;
        endcase
    end

    // hi/lo write port, unchanged halves pass back in
    always_comb begin
        hilo_we_o = 1'b0;
        hi_o      = hi_i;
        lo_o      = lo_i;
        case (aluop_i)
            OP_MULT, OP_MULTU: begin
                hilo_we_o = 1'b1;
                {hi_o, lo_o} = mul_res_i;
            end
            OP_MTHI: begin
                hilo_we_o = 1'b1;
                hi_o      = reg1_i;
            end
            OP_MTLO: begin
                hilo_we_o = 1'b1;
                lo_o      = reg1_i;
            end
            OP_MADD, OP_MADDU, OP_MSUB, OP_MSUBU: begin
                // second cycle only
                hilo_we_o = mac_done_i;
                {hi_o, lo_o} = mac_res_i;
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

// ==== rtl/hilo_reg.sv ====
`timescale 1ns/1ps
`default_nettype none

module hilo_reg (
    input  wire                clk,
    input  wire                rst_i,
    input  wire                we_i,
    input  wire ex_pkg::word_t hi_i,
    input  wire ex_pkg::word_t lo_i,
    output ex_pkg::word_t      hi_o,
    output ex_pkg::word_t      lo_o
);
    import ex_pkg::*;

    word_t hi_q;
    word_t lo_q;

    // both halves load together
    always_ff @(posedge clk) begin
        if (rst_i) begin
            hi_q <= '0;
            lo_q <= '0;
        end else if (we_i) begin
            hi_q <= hi_i;
            lo_q <= lo_i;
        end
    end

    assign hi_o = hi_q;
    assign lo_o = lo_q;

endmodule

`default_nettype wire

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the ex_stage testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert -Wno-fatal --top-module tb_ex_stage -f filelist.f \
    && ./obj_dir/Vtb_ex_stage > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "build or simulation did not complete"; exit 1; }

cat sim.log
grep -q "TB FAILED" sim.log && exit 1 || exit 0

// ==== verif/ex_stage_asserts.sv ====
`timescale 1ns/1ps
`default_nettype none

module ex_stage_asserts (
    input wire                 clk,
    input wire                 rst_i,
    input wire ex_pkg::aluop_t aluop_i,
    input wire ex_pkg::word_t  reg1_i,
    input wire ex_pkg::word_t  reg2_i,
    input wire                 stall_i,
    input wire                 wb_wreg_i
);
    import ex_pkg::*;

    logic  mac_op;
    word_t sum_w;
    word_t diff_w;
    logic  signed_ovf;

    assign mac_op = (aluop_i == OP_MADD) || (aluop_i == OP_MADDU) ||
                    (aluop_i == OP_MSUB) || (aluop_i == OP_MSUBU);

    assign sum_w  = reg1_i + reg2_i;
    assign diff_w = reg1_i - reg2_i;

    // operand signs against the sign of the result
    assign signed_ovf =
        ((aluop_i == OP_ADD) && (reg1_i[WORD_W-1] == reg2_i[WORD_W-1]) &&
         (sum_w[WORD_W-1] != reg1_i[WORD_W-1])) ||
        ((aluop_i == OP_SUB) && (reg1_i[WORD_W-1] != reg2_i[WORD_W-1]) &&
         (diff_w[WORD_W-1] != reg1_i[WORD_W-1]));

    // first edge out of reset finds the sequencer idle
    stall_after_reset: assert property (@(posedge clk) rst_i |=> !stall_i)
        else $error("stall_o high right after reset");

    // accumulate stalls for one cycle only
    stall_one_cycle: assert property (@(posedge clk) disable iff (rst_i) stall_i |=> !stall_i)
        else $error("stall_o held high for more than one cycle");

    // an accumulate without stall is in its second cycle
    mac_second_cycle: assert property (@(posedge clk) disable iff (rst_i)
        mac_op && !stall_i |-> $past(stall_i))
        else $error("accumulate finished without its stall cycle");

    ovf_blocks_write: assert property (@(posedge clk) disable iff (rst_i)
        signed_ovf |-> !wb_wreg_i)
        else $error("wreg_o high while signed overflow occurs");

endmodule

`default_nettype wire

// ==== verif/tb_ex_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_ex_stage;
    import ex_pkg::*;

    localparam int RESET_CYCLES = 16;
    // logic/shift, arith with corners, mul, hilo, accumulate
    localparam int TEST_CYCLES  = 7 * 8 + 8 * (8 + 5 * 5) + 4 + 4 * 3 + 4 * 3 * 2;
    localparam int TIMEOUT_NS   = (TEST_CYCLES + RESET_CYCLES) * 40 * 2;

    logic      clk = 1'b0;
    logic      rst_i;
    aluop_t    aluop_i;
    alusel_t   alusel_i;
    word_t     reg1_i;
    word_t     reg2_i;
    reg_addr_t wd_i;
    logic      wreg_i;
    reg_addr_t wd_o;
    logic      wreg_o;
    word_t     wdata_o;
    logic      stall_o;
    word_t     hi_o;
    word_t     lo_o;

    integer    seed;
    int        err_count;
    logic      check_en;
    string     test_name;
    word_t     exp_wdata;
    logic      exp_wreg;
    reg_addr_t exp_wd;
    logic      exp_stall;
    word_t     exp_hi_n;
    word_t     exp_lo_n;
    word_t     model_hi;
    word_t     model_lo;

    aluop_t logic_ops[7] = '{OP_OR, OP_AND, OP_XOR, OP_NOR, OP_SLL, OP_SRL, OP_SRA};
    aluop_t arith_ops[8] = '{OP_ADD, OP_ADDU, OP_SUB, OP_SUBU, OP_SLT, OP_SLTU, OP_CLZ, OP_CLO};
    aluop_t hilo_ops[4]  = '{OP_MULT, OP_MULTU, OP_MTHI, OP_MTLO};
    aluop_t mac_ops[4]   = '{OP_MADD, OP_MADDU, OP_MSUB, OP_MSUBU};
    word_t  corner_vals[5] = '{32'h0000_0000, 32'h0000_0001, 32'h7fff_ffff,
                               32'h8000_0000, 32'hffff_ffff};

    ex_stage UUT (
        .clk      (clk),
        .rst_i    (rst_i),
        .aluop_i  (aluop_i),
        .alusel_i (alusel_i),
        .reg1_i   (reg1_i),
        .reg2_i   (reg2_i),
        .wd_i     (wd_i),
        .wreg_i   (wreg_i),
        .wd_o     (wd_o),
        .wreg_o   (wreg_o),
        .wdata_o  (wdata_o),
        .stall_o  (stall_o),
        .hi_o     (hi_o),
        .lo_o     (lo_o)
    );

    bind ex_stage ex_stage_asserts u_asserts (
        .clk       (clk),
        .rst_i     (rst_i),
        .aluop_i   (aluop_i),
        .reg1_i    (reg1_i),
        .reg2_i    (reg2_i),
        .stall_i   (stall_o),
        .wb_wreg_i (wreg_o)
    );

    always #20 clk = ~clk;

    function automatic alusel_t sel_for(input aluop_t op);
        case (op)
            OP_OR, OP_AND, OP_XOR, OP_NOR:  return SEL_LOGIC;
            OP_SLL, OP_SRL, OP_SRA:         return SEL_SHIFT;
            OP_ADD, OP_ADDU, OP_SUB, OP_SUBU,
            OP_SLT, OP_SLTU, OP_CLZ, OP_CLO: return SEL_ARITH;
            OP_MUL:                         return SEL_MUL;
            OP_MFHI, OP_MFLO:               return SEL_MOVE;
            default:                        return SEL_NOP;
        endcase
    endfunction

    function automatic logic is_accumulate(input aluop_t op);
        return (op == OP_MADD) || (op == OP_MADDU) || (op == OP_MSUB) || (op == OP_MSUBU);
    endfunction

    // run of bits equal to bitv, from the top
    function automatic word_t count_lead(input word_t v, input logic bitv);
        word_t n;
        n = '0;
        for (int i = WORD_W - 1; i >= 0; i--) begin
            if (v[i] != bitv) break;
            n = n + 1;
        end
        return n;
    endfunction

    function automatic void ref_model(input aluop_t op, input word_t a, input word_t b,
                                      input logic wr, input word_t hi, input word_t lo,
                                      output word_t wdata, output logic wreg,
                                      output word_t hi_n, output word_t lo_n);
        longint s;
        dword_t sprod;
        dword_t uprod;
        wdata = '0;
        wreg  = wr;
        hi_n  = hi;
        lo_n  = lo;
        sprod = $signed({{32{a[31]}}, a}) * $signed({{32{b[31]}}, b});
        uprod = {32'b0, a} * {32'b0, b};
        case (op)
            OP_OR:   wdata = a | b;
            OP_AND:  wdata = a & b;
            OP_XOR:  wdata = a ^ b;
            OP_NOR:  wdata = ~(a | b);
            OP_SLL:  wdata = b << a[4:0];
            OP_SRL:  wdata = b >> a[4:0];
            OP_SRA:  wdata = $signed(b) >>> a[4:0];
            OP_ADD: begin
                s     = longint'($signed(a)) + longint'($signed(b));
                wdata = a + b;
                wreg  = wr && (s == longint'($signed(wdata)));
            end
            OP_SUB: begin
                s     = longint'($signed(a)) - longint'($signed(b));
                wdata = a - b;
                wreg  = wr && (s == longint'($signed(wdata)));
            end
            OP_ADDU: wdata = a + b;
            OP_SUBU: wdata = a - b;
            OP_SLT:  wdata = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            OP_SLTU: wdata = (a < b) ? 32'd1 : 32'd0;
            OP_CLZ:  wdata = count_lead(a, 1'b0);
            OP_CLO:  wdata = count_lead(a, 1'b1);
            OP_MUL:  wdata = sprod[31:0];
            OP_MULT:  {hi_n, lo_n} = sprod;
            OP_MULTU: {hi_n, lo_n} = uprod;
            OP_MADD:  {hi_n, lo_n} = {hi, lo} + sprod;
            OP_MADDU: {hi_n, lo_n} = {hi, lo} + uprod;
            OP_MSUB:  {hi_n, lo_n} = {hi, lo} - sprod;
            OP_MSUBU: {hi_n, lo_n} = {hi, lo} - uprod;
            OP_MFHI: wdata = hi;
            OP_MFLO: wdata = lo;
            OP_MTHI: hi_n = a;
            OP_MTLO: lo_n = a;
            default: ;
        endcase
    endfunction

    task automatic check_word(input string name, input string what,
                              input word_t exp, input word_t act);
        if (act !== exp) begin
            err_count++;
            $display("[ERROR] %s %s expected %h actual %h", name, what, exp, act);
        end
    endtask

    task automatic check_flag(input string name, input string what,
                              input logic exp, input logic act);
        if (act !== exp) begin
            err_count++;
            $display("[ERROR] %s %s expected %b actual %b", name, what, exp, act);
        end
    endtask

    task automatic check_addr(input string name, input string what,
                              input reg_addr_t exp, input reg_addr_t act);
        if (act !== exp) begin
            err_count++;
            $display("[ERROR] %s %s expected %h actual %h", name, what, exp, act);
        end
    endtask

    // one instruction, held a second cycle for an accumulate
    task automatic issue(input string group, input aluop_t op, input word_t a, input word_t b);
        alusel_t   sel;
        logic      wr;
        reg_addr_t wd;
        word_t     wdata_n;
        logic      wreg_n;
        word_t     hi_n;
        word_t     lo_n;
        sel = sel_for(op);
        wr  = (sel != SEL_NOP);
        wd  = reg_addr_t'($random(seed));
        @(negedge clk);
        ref_model(op, a, b, wr, model_hi, model_lo, wdata_n, wreg_n, hi_n, lo_n);
        aluop_i   = op;
        alusel_i  = sel;
        reg1_i    = a;
        reg2_i    = b;
        wd_i      = wd;
        wreg_i    = wr;
        test_name = $sformatf("%s op=%h", group, op);
        exp_wdata = wdata_n;
        exp_wreg  = wreg_n;
        exp_wd    = wd;
        exp_hi_n  = hi_n;
        exp_lo_n  = lo_n;
        exp_stall = is_accumulate(op);
        check_en  = 1'b1;
        if (is_accumulate(op)) begin
            @(negedge clk);
            exp_stall = 1'b0;
        end
    endtask

    always @(posedge clk) begin
        if (check_en) begin
            check_word(test_name, "wdata_o", exp_wdata, wdata_o);
            check_flag(test_name, "wreg_o", exp_wreg, wreg_o);
            check_addr(test_name, "wd_o", exp_wd, wd_o);
            check_flag(test_name, "stall_o", exp_stall, stall_o);
            check_word(test_name, "hi_o", model_hi, hi_o);
            check_word(test_name, "lo_o", model_lo, lo_o);
            // hi/lo take the new value at the end of the last cycle
            if (!exp_stall) begin
                model_hi = exp_hi_n;
                model_lo = exp_lo_n;
            end
        end
    end

    initial begin
        #(TIMEOUT_NS);
        $display("timeout: the test sequence did not finish within %0d ns", TIMEOUT_NS);
        $display("TB FAILED");
        $finish;
    end

    initial begin
        seed      = 32'h6580;
        err_count = 0;
        check_en  = 1'b0;
        model_hi  = '0;
        model_lo  = '0;
        rst_i     = 1'b1;
        aluop_i   = OP_NOP;
        alusel_i  = SEL_NOP;
        reg1_i    = '0;
        reg2_i    = '0;
        wd_i      = '0;
        wreg_i    = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst_i = 1'b0;
        check_word("reset", "hi_o", '0, hi_o);
        check_word("reset", "lo_o", '0, lo_o);
        check_flag("reset", "stall_o", 1'b0, stall_o);

        foreach (logic_ops[i]) begin
            repeat (8) issue("logic_shift", logic_ops[i], $random(seed), $random(seed));
        end
        foreach (arith_ops[i]) begin
            repeat (8) issue("arith", arith_ops[i], $random(seed), $random(seed));
            foreach (corner_vals[j]) begin
                foreach (corner_vals[k]) begin
                    issue("arith_corner", arith_ops[i], corner_vals[j], corner_vals[k]);
                end
            end
        end
        repeat (4) issue("mul", OP_MUL, $random(seed), $random(seed));
        foreach (hilo_ops[i]) begin
            issue("hilo", hilo_ops[i], $random(seed), $random(seed));
            issue("hilo_read", OP_MFHI, $random(seed), $random(seed));
            issue("hilo_read", OP_MFLO, $random(seed), $random(seed));
        end
        foreach (mac_ops[i]) begin
            repeat (3) issue("mac", mac_ops[i], $random(seed), $random(seed));
        end

        @(negedge clk);
        check_en = 1'b0;
        $display("checks complete with %0d error(s)", err_count);
        if (err_count == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
